//--- mini_macros.svh
`ifndef MINI_MACROS_SVH
`define MINI_MACROS_SVH

// Data word width, also the instruction word width
`define MINI_XLEN 32

// Instruction memory sizing
`define MINI_IMEM_DEPTH 1024
`define MINI_IMEM_AW 10

// Data memory sizing
// 6-bit address lines up with instruction field A
`define MINI_DMEM_DEPTH 64
`define MINI_DMEM_AW 6

`endif

//--- mini_isa_pkg.sv
package mini_isa_pkg;

    // One 32-bit instruction word, two decodings
    // Opcode always sits in bits 31..25
    typedef union packed {
        // Arithmetic view, A and B are operands
        struct packed {
            logic [6:0]  opcode;
            logic [5:0]  src_a;
            logic [5:0]  src_b;
            logic [12:0] unused;
        } alu;
        // Memory view, A is the address and B the store value
        struct packed {
            logic [6:0]  opcode;
            logic [5:0]  addr;
            logic [5:0]  value;
            logic [12:0] unused;
        } mem;
    } instr_u;

    // Opcode values
    localparam logic [6:0] OP_ADD   = 7'd0;
    localparam logic [6:0] OP_STORE = 7'd1;
    localparam logic [6:0] OP_LOAD  = 7'd2;
    localparam logic [6:0] OP_HALT  = 7'd3;

endpackage

//--- mem_if.sv
`timescale 1ns/100ps
`include "mini_macros.svh"

interface mem_if;

    // Write strobe, valid for one execute cycle
    logic                     we;
    logic [`MINI_DMEM_AW-1:0] addr;
    logic [`MINI_XLEN-1:0]    wdata;
    // Read data, combinational from addr
    logic [`MINI_XLEN-1:0]    rdata;

    // Execute stage side
    modport master (
        output we, addr, wdata,
        input  rdata
    );

    // Memory side
    modport slave (
        input  we, addr, wdata,
        output rdata
    );

endinterface

//--- instr_store.sv
`timescale 1ns/100ps
`include "mini_macros.svh"

module instr_store (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_req,
    input  logic [`MINI_IMEM_AW-1:0] load_addr,
    input  logic [`MINI_XLEN-1:0]    load_data,
    output logic                     load_ack,
    input  logic [`MINI_IMEM_AW-1:0] fetch_addr,
    output logic [`MINI_XLEN-1:0]    fetch_instr
);

    // Handshake states
    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_ACK  = 1'b1;

    logic [`MINI_XLEN-1:0] imem [`MINI_IMEM_DEPTH];
    logic                  ld_state;
    logic                  ld_write;

    // Only the first cycle of a request writes
    assign ld_write = (ld_state == ST_IDLE) && load_req;

    // Ack is high for the whole ACK state
    assign load_ack = (ld_state == ST_ACK);

    // Four-phase load FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_state <= ST_IDLE;
        end else begin
            case (ld_state)
                ST_IDLE: begin
                    // Req seen, ack next cycle
                    if (load_req)
                        ld_state <= ST_ACK;
                end
                default: begin
                    // Host dropped req, release ack
                    if (!load_req)
                        ld_state <= ST_IDLE;
                end
            endcase
        end
    end

    // Memory array, host write and registered fetch read
    always_ff @(posedge clk) begin
        if (ld_write)
            imem[load_addr] <= load_data;
        fetch_instr <= imem[fetch_addr];
    end

endmodule

//--- fetch_unit.sv
`timescale 1ns/100ps
`include "mini_macros.svh"

module fetch_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  logic                     halt_seen,
    output logic [`MINI_IMEM_AW-1:0] fetch_addr,
    output logic                     issue_valid,
    output logic [`MINI_IMEM_AW-1:0] issue_pc
);

    logic [`MINI_IMEM_AW-1:0] pc;

    // Memory address is the live pc
    assign fetch_addr = pc;

    // Pc and one-cycle delayed issue info
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc          <= '0;
            issue_valid <= 1'b0;
            issue_pc    <= '0;
        end else if (!run) begin
            // Stopped, park at address 0
            // Idle issue with pc 0 also tells execute to drop halt
            pc          <= '0;
            issue_valid <= 1'b0;
            issue_pc    <= '0;
        end else if (halt_seen) begin
            // Squash the word behind HALT
            // Pc and issue_pc freeze
            issue_valid <= 1'b0;
        end else begin
            // Normal flow, one word per cycle
            pc          <= pc + 1'b1;
            issue_valid <= 1'b1;
            // Lines up with the registered memory read
            issue_pc    <= pc;
        end
    end

endmodule

//--- exec_unit.sv
`timescale 1ns/100ps
`include "mini_macros.svh"

module exec_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue_valid,
    input  logic [`MINI_IMEM_AW-1:0] issue_pc,
    input  logic [`MINI_XLEN-1:0]    fetch_instr,
    mem_if.master                    dmem,
    output logic                     halt_seen,
    output logic                     commit_valid,
    output logic [`MINI_IMEM_AW-1:0] commit_pc,
    output logic [`MINI_XLEN-1:0]    acc,
    output logic [`MINI_XLEN-1:0]    data_out
);

    mini_isa_pkg::instr_u  instr;
    logic [6:0]            opcode;
    logic                  do_exec;
    logic                  fetch_idle;
    logic [`MINI_XLEN-1:0] add_sum;

    assign instr  = fetch_instr;
    // Opcode bits are shared by both views
    assign opcode = instr.alu.opcode;

    // Nothing executes once HALT has been taken
    assign do_exec = issue_valid && !halt_seen;

    // Fetch parked at pc 0 with no issue, i.e. run is low
    assign fetch_idle = !issue_valid && (issue_pc == '0);

    // ADD through the alu view, zero-extended operands
    assign add_sum = `MINI_XLEN'(instr.alu.src_a) + `MINI_XLEN'(instr.alu.src_b);

    // Data memory bus through the mem view
    // STORE lands at the end of this cycle
    assign dmem.we    = do_exec && (opcode == mini_isa_pkg::OP_STORE);
    assign dmem.addr  = instr.mem.addr;
    assign dmem.wdata = `MINI_XLEN'(instr.mem.value);

    // Commit record and architectural state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
            commit_pc    <= '0;
            acc          <= '0;
            data_out     <= '0;
        end else begin
            // Single-cycle pulse per executed word
            commit_valid <= do_exec;
            if (do_exec) begin
                commit_pc <= issue_pc;
                case (opcode)
                    mini_isa_pkg::OP_ADD:  acc      <= add_sum;
                    mini_isa_pkg::OP_LOAD: data_out <= dmem.rdata;
                    // STORE goes out on the bus, HALT and unknowns change nothing here
                    default: ;
                endcase
            end
        end
    end

    // Halt flag, set by HALT, dropped once fetch goes idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt_seen <= 1'b0;
        end else if (do_exec && (opcode == mini_isa_pkg::OP_HALT)) begin
            halt_seen <= 1'b1;
        end else if (fetch_idle) begin
            halt_seen <= 1'b0;
        end
    end

endmodule

//--- data_mem.sv
`timescale 1ns/100ps
`include "mini_macros.svh"

module data_mem (
    input  logic  clk,
    input  logic  rst_n,
    mem_if.slave  bus
);

    logic [`MINI_XLEN-1:0] mem [`MINI_DMEM_DEPTH];

    // Register file storage, whole array zeroed at reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem <= '{default: '0};
        end else if (bus.we) begin
            mem[bus.addr] <= bus.wdata;
        end
    end

    // Asynchronous read
    // A LOAD right after a STORE sees the new word
    assign bus.rdata = mem[bus.addr];

endmodule

//--- mini_core_top.sv
`timescale 1ns/100ps
`include "mini_macros.svh"

module mini_core_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  logic                     load_req,
    input  logic [`MINI_IMEM_AW-1:0] load_addr,
    input  logic [`MINI_XLEN-1:0]    load_data,
    output logic                     load_ack,
    output logic                     commit_valid,
    output logic [`MINI_IMEM_AW-1:0] commit_pc,
    output logic [`MINI_XLEN-1:0]    acc,
    output logic [`MINI_XLEN-1:0]    data_out,
    output logic                     halted
);

    logic [`MINI_IMEM_AW-1:0] fetch_addr;
    logic [`MINI_XLEN-1:0]    fetch_instr;
    logic                     issue_valid;
    logic [`MINI_IMEM_AW-1:0] issue_pc;
    logic                     halt_seen;

    // Execute to data memory
    mem_if i_dmem_bus ();

    // Program storage, host load and fetch read
    instr_store i_instr_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_req    (load_req),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .load_ack    (load_ack),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr)
    );

    // Fetch stage
    fetch_unit i_fetch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .halt_seen   (halt_seen),
        .fetch_addr  (fetch_addr),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc)
    );

    // Execute stage and commit
    exec_unit i_exec_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_pc     (issue_pc),
        .fetch_instr  (fetch_instr),
        .dmem         (i_dmem_bus.master),
        .halt_seen    (halt_seen),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .acc          (acc),
        .data_out     (data_out)
    );

    data_mem i_data_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (i_dmem_bus.slave)
    );

    // Halt status straight from execute
    assign halted = halt_seen;

endmodule

//--- tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset low for 16 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- mini_core_sva.sv
`timescale 1ns/100ps

module mini_core_sva (
    input logic clk,
    input logic rst_n,
    input logic run,
    input logic load_req,
    input logic load_ack,
    input logic commit_valid,
    input logic halted
);

    // Ack one cycle after a new request
    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(load_req) |=> load_ack)
        else $error("load_ack did not follow load_req");

    // Ack released one cycle after req drops
    ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(load_req) |=> !load_ack)
        else $error("load_ack stayed high after load_req fell");

    // Ack never falls while req still high
    ack_fall_order: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(load_ack) |-> !$past(load_req))
        else $error("load_ack fell before load_req");

    // Host loads only while stopped
    load_while_stopped: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(load_req) |-> !run)
        else $error("load_req rose while run was high");

    // Halted holds until run drops
    halt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (halted && run) |=> halted)
        else $error("halted dropped while run was high");

    // Nothing commits once halted
    no_commit_halted: assert property (@(posedge clk) disable iff (!rst_n)
        (halted && $past(halted)) |-> !commit_valid)
        else $error("commit_valid while halted");

endmodule

bind mini_core_top mini_core_sva i_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .load_req     (load_req),
    .load_ack     (load_ack),
    .commit_valid (commit_valid),
    .halted       (halted)
);

//--- tb_checker.sv
`timescale 1ns/100ps
`include "mini_macros.svh"

module tb_checker #(
    parameter int NROWS    = 1,
    parameter int NCOMMITS = 1
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  logic                     load_ack,
    input  logic                     commit_valid,
    input  logic [`MINI_IMEM_AW-1:0] commit_pc,
    input  logic [`MINI_XLEN-1:0]    acc,
    input  logic [`MINI_XLEN-1:0]    data_out,
    input  logic                     halted,
    input  logic [`MINI_XLEN-1:0]    exp_acc [NROWS],
    input  logic [`MINI_XLEN-1:0]    exp_dout [NROWS],
    input  int                       test_id [NROWS],
    output int                       pass_count,
    output int                       fail_count,
    output int                       commit_count
);

    logic idle_ok;
    logic idle_done;

    // Reset and pre-run state check
    // Closes as one test when run rises
    task automatic check_idle();
        if (!rst_n && (load_ack !== 1'b0)) begin
            $display("[ERROR] %0t ns: load_ack high during reset", $time);
            idle_ok = 1'b0;
        end
        if ((commit_valid !== 1'b0) || (halted !== 1'b0) ||
            (acc !== '0) || (data_out !== '0)) begin
            $display("[ERROR] %0t ns: not idle before run (cv=%0b halted=%0b acc=%0h dout=%0h)",
                     $time, commit_valid, halted, acc, data_out);
            idle_ok = 1'b0;
        end
        if (run) begin
            idle_done = 1'b1;
            if (idle_ok) begin
                pass_count++;
                $display("Test idle (behavior 1): ok");
            end else begin
                fail_count++;
                $display("Test idle (behavior 1): failed");
            end
        end
    endtask

    // One commit against the next table row
    task automatic check_commit();
        int   idx;
        logic ok;
        idx = commit_count;
        commit_count++;
        ok = 1'b1;
        if (idx >= NCOMMITS) begin
            $display("[ERROR] %0t ns: commit at pc %0d after HALT", $time, commit_pc);
            fail_count++;
        end else begin
            if (commit_pc !== `MINI_IMEM_AW'(idx)) begin
                $display("[ERROR] %0t ns: commit_pc %0d, expected %0d", $time, commit_pc, idx);
                ok = 1'b0;
            end
            if (acc !== exp_acc[idx]) begin
                $display("[ERROR] %0t ns: pc %0d acc %0h, expected %0h",
                         $time, idx, acc, exp_acc[idx]);
                ok = 1'b0;
            end
            if (data_out !== exp_dout[idx]) begin
                $display("[ERROR] %0t ns: pc %0d data_out %0h, expected %0h",
                         $time, idx, data_out, exp_dout[idx]);
                ok = 1'b0;
            end
            // Halted comes up together with the HALT commit only
            if (halted !== (idx == NCOMMITS - 1)) begin
                $display("[ERROR] %0t ns: pc %0d halted %0b", $time, idx, halted);
                ok = 1'b0;
            end
            if (ok) begin
                pass_count++;
                $display("Test pc %0d (behavior %0d): ok", idx, test_id[idx]);
            end else begin
                fail_count++;
                $display("Test pc %0d (behavior %0d): failed", idx, test_id[idx]);
            end
        end
    endtask

    // Outputs are sampled on the falling edge
    initial begin
        pass_count   = 0;
        fail_count   = 0;
        commit_count = 0;
        idle_ok      = 1'b1;
        idle_done    = 1'b0;
        forever begin
            @(negedge clk);
            if (!idle_done)
                check_idle();
            if (commit_valid)
                check_commit();
        end
    end

endmodule

//--- tb_top.sv
`timescale 1ns/100ps
`include "mini_macros.svh"

module tb_top;

    localparam int NROWS    = 10;
    // HALT sits in row 8
    // Row 9 must never commit
    localparam int NCOMMITS = 9;
    localparam int LIMIT    = NROWS * 4 + 16 + 100;

    logic                     clk;
    logic                     rst_n;
    logic                     run;
    logic                     load_req;
    logic [`MINI_IMEM_AW-1:0] load_addr;
    logic [`MINI_XLEN-1:0]    load_data;
    logic                     load_ack;
    logic                     commit_valid;
    logic [`MINI_IMEM_AW-1:0] commit_pc;
    logic [`MINI_XLEN-1:0]    acc;
    logic [`MINI_XLEN-1:0]    data_out;
    logic                     halted;

    // Stimulus table with expected state after each commit
    logic [`MINI_XLEN-1:0] tbl_instr [NROWS];
    logic [`MINI_XLEN-1:0] tbl_acc [NROWS];
    logic [`MINI_XLEN-1:0] tbl_dout [NROWS];
    int                    tbl_id [NROWS];

    int pass_count;
    int fail_count;
    int commit_count;
    int cycles = 0;

    tb_clkgen i_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mini_core_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .load_req     (load_req),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .load_ack     (load_ack),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .acc          (acc),
        .data_out     (data_out),
        .halted       (halted)
    );

    tb_checker #(
        .NROWS    (NROWS),
        .NCOMMITS (NCOMMITS)
    ) i_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .load_ack     (load_ack),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .acc          (acc),
        .data_out     (data_out),
        .halted       (halted),
        .exp_acc      (tbl_acc),
        .exp_dout     (tbl_dout),
        .test_id      (tbl_id),
        .pass_count   (pass_count),
        .fail_count   (fail_count),
        .commit_count (commit_count)
    );

    // Opcode 31..25, A 24..19, B 18..13, rest unused
    function automatic logic [`MINI_XLEN-1:0] make_word(input logic [6:0] op,
                                                        input logic [5:0] a,
                                                        input logic [5:0] b);
        return {op, a, b, 13'h0};
    endfunction

    task automatic set_row(input int row, input logic [`MINI_XLEN-1:0] word, input int id);
        tbl_instr[row] = word;
        tbl_id[row]    = id;
    endtask

    // Program rows and their expected values from the ISA rules
    task automatic fill_table();
        logic [`MINI_XLEN-1:0] m_acc;
        logic [`MINI_XLEN-1:0] m_dout;
        logic [`MINI_XLEN-1:0] m_mem [64];
        logic [6:0]            op;
        logic [5:0]            a;
        logic [5:0]            b;
        set_row(0, make_word(mini_isa_pkg::OP_ADD, 6'd5, 6'd7), 3);
        set_row(1, make_word(mini_isa_pkg::OP_ADD, 6'd63, 6'd63), 3);
        set_row(2, make_word(mini_isa_pkg::OP_ADD, 6'($urandom()), 6'($urandom())), 3);
        set_row(3, make_word(mini_isa_pkg::OP_ADD, 6'($urandom()), 6'($urandom())), 3);
        set_row(4, make_word(mini_isa_pkg::OP_STORE, 6'd9, 6'd42), 4);
        set_row(5, make_word(mini_isa_pkg::OP_LOAD, 6'd9, 6'd0), 4);
        // Never written address reads back 0
        set_row(6, make_word(mini_isa_pkg::OP_LOAD, 6'd20, 6'd0), 4);
        // A points at the stored word, so a wrong LOAD decode shows up
        set_row(7, make_word(7'h55, 6'd9, 6'd4), 5);
        set_row(8, make_word(mini_isa_pkg::OP_HALT, 6'd0, 6'd0), 6);
        // Squashed behind HALT
        set_row(9, make_word(mini_isa_pkg::OP_ADD, 6'd1, 6'd1), 6);
        m_acc  = '0;
        m_dout = '0;
        for (int i = 0; i < 64; i++)
            m_mem[i] = '0;
        for (int i = 0; i < NROWS; i++) begin
            op = tbl_instr[i][31:25];
            a  = tbl_instr[i][24:19];
            b  = tbl_instr[i][18:13];
            case (op)
                mini_isa_pkg::OP_ADD:   m_acc = 32'(a) + 32'(b);
                mini_isa_pkg::OP_STORE: m_mem[a] = 32'(b);
                mini_isa_pkg::OP_LOAD:  m_dout = m_mem[a];
                default: ;
            endcase
            tbl_acc[i]  = m_acc;
            tbl_dout[i] = m_dout;
        end
    endtask

    // Four-phase write of one instruction word
    task automatic load_word(input logic [`MINI_IMEM_AW-1:0] addr,
                             input logic [`MINI_XLEN-1:0] data);
        @(negedge clk);
        load_addr = addr;
        load_data = data;
        load_req  = 1'b1;
        @(negedge clk);
        while (!load_ack)
            @(negedge clk);
        load_req = 1'b0;
        @(negedge clk);
        while (load_ack)
            @(negedge clk);
    endtask

    task automatic finish_run();
        int failed;
        failed = fail_count;
        if (commit_count < NCOMMITS) begin
            $display("Missing commits: expected %0d, saw only %0d", NCOMMITS, commit_count);
            failed = failed + (NCOMMITS - commit_count);
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, failed);
        if (failed == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    endtask

    initial begin
        run       = 1'b0;
        load_req  = 1'b0;
        load_addr = '0;
        load_data = '0;
        void'($urandom(32'h197b));
        fill_table();
        @(posedge rst_n);
        for (int i = 0; i < NROWS; i++)
            load_word(`MINI_IMEM_AW'(i), tbl_instr[i]);
        @(negedge clk);
        run = 1'b1;
        @(negedge clk);
        while (!halted)
            @(negedge clk);
        // Room for a stray commit to show up
        repeat (8) @(negedge clk);
        finish_run();
    end

    // Watchdog on total cycles
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

//--- compile.f
+incdir+.
mini_isa_pkg.sv
mem_if.sv
instr_store.sv
fetch_unit.sv
exec_unit.sv
data_mem.sv
mini_core_top.sv
tb_clkgen.sv
mini_core_sva.sv
tb_checker.sv
tb_top.sv

//--- run.sh
#!/bin/sh
set -e

rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -f compile.f -o tb_sim
# A crash or assertion stop leaves no pass line in the log
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "run.sh: simulation passed"
    exit 0
else
    echo "run.sh: simulation failed"
    exit 1
fi
